// File: id_stage.f
+incdir+.
mips_isa_pkg.sv
id_pkg.sv
id_decoder.sv
id_operand_sel.sv
id_ex_reg.sv
id_stage.sv
tb_id_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the id_stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f id_stage.f --top-module tb_id_stage -o sim_id_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_id_stage > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi

if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi

exit 0

// File: tb_id_model.svh
`ifndef TB_ID_MODEL_SVH
`define TB_ID_MODEL_SVH

// all-NOP bundle seen on id_ex_o during reset
function automatic id_pkg::id_ex_t nop_bundle();
    id_pkg::id_ex_t b;
    b.ctrl.aluop        = id_pkg::ALU_NOP;
    b.ctrl.alusel       = id_pkg::SEL_NOP;
    b.ctrl.wd           = 5'd0;
    b.ctrl.wreg         = 1'b0;
    b.ctrl.inst_invalid = 1'b0;
    b.reg1              = 32'd0;
    b.reg2              = 32'd0;
    return b;
endfunction

// expected decode of one instruction word
function automatic void expect_decode(
    input  mips_isa_pkg::word_t inst,
    output id_pkg::id_ctrl_t    ctrl,
    output logic                rd1,
    output logic                rd2,
    output mips_isa_pkg::word_t imm
);
    mips_isa_pkg::opcode_t op;
    mips_isa_pkg::funct_t  fn;
    mips_isa_pkg::imm16_t  fld;
    logic                  valid;
    logic                  rt_dst;
    id_pkg::alu_op_e       aluop;
    id_pkg::alu_sel_e      alusel;
    op     = inst[31:26];
    fn     = inst[5:0];
    fld    = inst[15:0];
    valid  = 1'b1;
    rt_dst = 1'b1;
    rd1    = 1'b1;
    rd2    = 1'b0;
    imm    = 32'd0;
    aluop  = id_pkg::ALU_NOP;
    if (op == mips_isa_pkg::OP_SPECIAL) begin
        rt_dst = 1'b0;
        if (inst[31:21] == 11'd0 && (fn == mips_isa_pkg::FN_SLL ||
            fn == mips_isa_pkg::FN_SRL || fn == mips_isa_pkg::FN_SRA)) begin
            rd1 = 1'b0;
            rd2 = 1'b1;
            imm = {27'd0, inst[10:6]};
            if (fn == mips_isa_pkg::FN_SLL) aluop = id_pkg::ALU_SLL;
            else if (fn == mips_isa_pkg::FN_SRL) aluop = id_pkg::ALU_SRL;
            else aluop = id_pkg::ALU_SRA;
        end else begin
            rd2 = 1'b1;
            if (inst[10:6] != 5'd0) valid = 1'b0;
            case (fn)
                mips_isa_pkg::FN_OR:   aluop = id_pkg::ALU_OR;
                mips_isa_pkg::FN_AND:  aluop = id_pkg::ALU_AND;
                mips_isa_pkg::FN_XOR:  aluop = id_pkg::ALU_XOR;
                mips_isa_pkg::FN_NOR:  aluop = id_pkg::ALU_NOR;
                mips_isa_pkg::FN_SLLV: aluop = id_pkg::ALU_SLL;
                mips_isa_pkg::FN_SRLV: aluop = id_pkg::ALU_SRL;
                mips_isa_pkg::FN_SRAV: aluop = id_pkg::ALU_SRA;
                mips_isa_pkg::FN_ADD:  aluop = id_pkg::ALU_ADD;
                mips_isa_pkg::FN_ADDU: aluop = id_pkg::ALU_ADDU;
                mips_isa_pkg::FN_SUB:  aluop = id_pkg::ALU_SUB;
                mips_isa_pkg::FN_SUBU: aluop = id_pkg::ALU_SUBU;
                mips_isa_pkg::FN_SLT:  aluop = id_pkg::ALU_SLT;
                mips_isa_pkg::FN_SLTU: aluop = id_pkg::ALU_SLTU;
                default:               valid = 1'b0;
            endcase
        end
    end else begin
        case (op)
            mips_isa_pkg::OP_ORI, mips_isa_pkg::OP_LUI: aluop = id_pkg::ALU_OR;
            mips_isa_pkg::OP_ANDI:  aluop = id_pkg::ALU_AND;
            mips_isa_pkg::OP_XORI:  aluop = id_pkg::ALU_XOR;
            mips_isa_pkg::OP_ADDI:  aluop = id_pkg::ALU_ADDI;
            mips_isa_pkg::OP_ADDIU: aluop = id_pkg::ALU_ADDIU;
            mips_isa_pkg::OP_SLTI:  aluop = id_pkg::ALU_SLT;
            mips_isa_pkg::OP_SLTIU: aluop = id_pkg::ALU_SLTU;
            default:                valid = 1'b0;
        endcase
        // extension of the 16-bit field
        if (op == mips_isa_pkg::OP_LUI) imm = {fld, 16'd0};
        else if (op[2] == 1'b1) imm = {16'd0, fld};
        else imm = {{16{fld[15]}}, fld};
    end
    case (aluop)
        id_pkg::ALU_OR, id_pkg::ALU_AND, id_pkg::ALU_XOR, id_pkg::ALU_NOR:
            alusel = id_pkg::SEL_LOGIC;
        id_pkg::ALU_SLL, id_pkg::ALU_SRL, id_pkg::ALU_SRA:
            alusel = id_pkg::SEL_SHIFT;
        default:
            alusel = id_pkg::SEL_ARITH;
    endcase
    ctrl.aluop        = valid ? aluop : id_pkg::ALU_NOP;
    ctrl.alusel       = valid ? alusel : id_pkg::SEL_NOP;
    ctrl.wd           = !valid ? 5'd0 : (rt_dst ? inst[20:16] : inst[15:11]);
    ctrl.wreg         = valid;
    ctrl.inst_invalid = !valid;
    if (!valid) begin
        rd1 = 1'b0;
        rd2 = 1'b0;
        imm = 32'd0;
    end
endfunction

// operand after forwarding, execute before memory
function automatic mips_isa_pkg::word_t expect_operand(
    input logic                    rd,
    input mips_isa_pkg::reg_addr_t addr,
    input mips_isa_pkg::word_t     reg_data,
    input mips_isa_pkg::word_t     imm,
    input id_pkg::fwd_src_t        ex_fwd,
    input id_pkg::fwd_src_t        mem_fwd
);
    if (!rd) return imm;
    if (ex_fwd.wreg && ex_fwd.wd == addr) return ex_fwd.wdata;
    if (mem_fwd.wreg && mem_fwd.wd == addr) return mem_fwd.wdata;
    return reg_data;
endfunction

`endif

// File: tb_id_stage.sv
`timescale 1ns/10ps

module tb_id_stage;

    localparam int  CLK_PERIOD   = 100;
    localparam int  RESET_CYCLES = 10;
    localparam int  NUM_VECTORS  = 2000;
    localparam int  CHK_W        = 82;

    logic                    clk_i;
    logic                    reset_i;
    mips_isa_pkg::word_t     inst_i;
    mips_isa_pkg::word_t     reg1_data_i;
    mips_isa_pkg::word_t     reg2_data_i;
    id_pkg::fwd_src_t        ex_fwd_i;
    id_pkg::fwd_src_t        mem_fwd_i;
    logic                    reg1_read_o;
    logic                    reg2_read_o;
    mips_isa_pkg::reg_addr_t reg1_addr_o;
    mips_isa_pkg::reg_addr_t reg2_addr_o;
    id_pkg::id_ex_t          id_ex_o;

    integer seed;
    int     checks;
    int     errors;

    id_pkg::id_ex_t exp_q[$];

    `include "tb_id_model.svh"

    id_stage dut0 (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .inst_i      (inst_i),
        .reg1_data_i (reg1_data_i),
        .reg2_data_i (reg2_data_i),
        .ex_fwd_i    (ex_fwd_i),
        .mem_fwd_i   (mem_fwd_i),
        .reg1_read_o (reg1_read_o),
        .reg2_read_o (reg2_read_o),
        .reg1_addr_o (reg1_addr_o),
        .reg2_addr_o (reg2_addr_o),
        .id_ex_o     (id_ex_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic check_value(input string name, input logic [CHK_W-1:0] exp,
                               input logic [CHK_W-1:0] got);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    function automatic mips_isa_pkg::funct_t rform_funct(input int idx);
        case (idx)
            0:       return mips_isa_pkg::FN_OR;
            1:       return mips_isa_pkg::FN_AND;
            2:       return mips_isa_pkg::FN_XOR;
            3:       return mips_isa_pkg::FN_NOR;
            4:       return mips_isa_pkg::FN_SLLV;
            5:       return mips_isa_pkg::FN_SRLV;
            6:       return mips_isa_pkg::FN_SRAV;
            7:       return mips_isa_pkg::FN_ADD;
            8:       return mips_isa_pkg::FN_ADDU;
            9:       return mips_isa_pkg::FN_SUB;
            10:      return mips_isa_pkg::FN_SUBU;
            11:      return mips_isa_pkg::FN_SLT;
            default: return mips_isa_pkg::FN_SLTU;
        endcase
    endfunction

    function automatic mips_isa_pkg::opcode_t imm_opcode(input int idx);
        case (idx)
            0:       return mips_isa_pkg::OP_ORI;
            1:       return mips_isa_pkg::OP_ANDI;
            2:       return mips_isa_pkg::OP_XORI;
            3:       return mips_isa_pkg::OP_LUI;
            4:       return mips_isa_pkg::OP_ADDI;
            5:       return mips_isa_pkg::OP_ADDIU;
            6:       return mips_isa_pkg::OP_SLTI;
            default: return mips_isa_pkg::OP_SLTIU;
        endcase
    endfunction

    // mostly legal encodings with a share of illegal ones
    task automatic random_inst(output mips_isa_pkg::word_t inst);
        logic [31:0] r;
        int          kind;
        int          idx;
        mips_isa_pkg::funct_t sfn;
        r    = $random(seed);
        kind = {$random(seed)} % 16;
        idx  = {$random(seed)} % 13;
        sfn  = (idx % 3 == 0) ? mips_isa_pkg::FN_SLL :
               ((idx % 3 == 1) ? mips_isa_pkg::FN_SRL : mips_isa_pkg::FN_SRA);
        if (kind < 6)
            inst = {mips_isa_pkg::OP_SPECIAL, r[25:11], 5'd0, rform_funct(idx)};
        else if (kind < 8)
            inst = {mips_isa_pkg::OP_SPECIAL, 5'd0, r[20:6], sfn};
        else if (kind < 13)
            inst = {imm_opcode(idx % 8), r[25:0]};
        else if (kind == 13)
            inst = {mips_isa_pkg::OP_SPECIAL, r[25:11], r[10:7], 1'b1, rform_funct(idx)};
        else if (kind == 14)
            inst = {mips_isa_pkg::OP_SPECIAL, r[25:22], 1'b1, r[20:6], sfn};
        else
            inst = r;
    endtask

    // address lands on rs or rt about a third of the time
    task automatic random_fwd(input mips_isa_pkg::word_t inst, output id_pkg::fwd_src_t f);
        int pick;
        logic [31:0] r;
        r       = $random(seed);
        pick    = {$random(seed)} % 6;
        f.wreg  = r[0];
        f.wdata = $random(seed);
        if (pick == 0) f.wd = inst[25:21];
        else if (pick == 1) f.wd = inst[20:16];
        else f.wd = r[5:1];
    endtask

    initial begin
        int                  i;
        mips_isa_pkg::word_t inst;
        mips_isa_pkg::word_t d1;
        mips_isa_pkg::word_t d2;
        mips_isa_pkg::word_t imm;
        id_pkg::fwd_src_t    exf;
        id_pkg::fwd_src_t    memf;
        id_pkg::id_ex_t      exp;
        logic                rd1;
        logic                rd2;
        seed        = 32'h681d_9fea;
        checks      = 0;
        errors      = 0;
        reset_i     = 1'b1;
        inst_i      = 32'd0;
        reg1_data_i = 32'd0;
        reg2_data_i = 32'd0;
        ex_fwd_i    = '0;
        mem_fwd_i   = '0;

        for (i = 0; i < RESET_CYCLES - 1; i++) begin
            @(posedge clk_i);
            #10;
            check_value("id_ex_o in reset", CHK_W'(nop_bundle()), CHK_W'(id_ex_o));
        end

        // last reset edge still ahead so the first result is the NOP bundle
        exp_q.push_back(nop_bundle());
        for (i = 0; i < NUM_VECTORS; i++) begin
            @(posedge clk_i);
            random_inst(inst);
            d1 = $random(seed);
            d2 = $random(seed);
            random_fwd(inst, exf);
            random_fwd(inst, memf);
            reset_i     <= 1'b0;
            inst_i      <= inst;
            reg1_data_i <= d1;
            reg2_data_i <= d2;
            ex_fwd_i    <= exf;
            mem_fwd_i   <= memf;

            expect_decode(inst, exp.ctrl, rd1, rd2, imm);
            exp.reg1 = expect_operand(rd1, inst[25:21], d1, imm, exf, memf);
            exp.reg2 = expect_operand(rd2, inst[20:16], d2, imm, exf, memf);
            exp_q.push_back(exp);

            #10;
            check_value("reg1_read_o", CHK_W'(rd1), CHK_W'(reg1_read_o));
            check_value("reg2_read_o", CHK_W'(rd2), CHK_W'(reg2_read_o));
            check_value("reg1_addr_o", CHK_W'(inst[25:21]), CHK_W'(reg1_addr_o));
            check_value("reg2_addr_o", CHK_W'(inst[20:16]), CHK_W'(reg2_addr_o));
            check_value("id_ex_o", CHK_W'(exp_q.pop_front()), CHK_W'(id_ex_o));
        end

        // last vector comes out one edge later
        @(posedge clk_i);
        #10;
        check_value("id_ex_o", CHK_W'(exp_q.pop_front()), CHK_W'(id_ex_o));

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #((RESET_CYCLES + NUM_VECTORS + 20) * CLK_PERIOD);
        $display("watchdog expired before the vectors were done");
        $display("checks %0d, errors %0d", checks, errors);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: id_stage.sv
`timescale 1ns/10ps

module id_stage (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  mips_isa_pkg::word_t     inst_i,
    input  mips_isa_pkg::word_t     reg1_data_i,
    input  mips_isa_pkg::word_t     reg2_data_i,
    input  id_pkg::fwd_src_t        ex_fwd_i,
    input  id_pkg::fwd_src_t        mem_fwd_i,
    output logic                    reg1_read_o,
    output logic                    reg2_read_o,
    output mips_isa_pkg::reg_addr_t reg1_addr_o,
    output mips_isa_pkg::reg_addr_t reg2_addr_o,
    output id_pkg::id_ex_t          id_ex_o
);

    id_pkg::id_ctrl_t    ctrl;
    mips_isa_pkg::word_t imm;
    mips_isa_pkg::word_t op1;
    mips_isa_pkg::word_t op2;

    id_decoder u_decoder (
        .inst_i      (inst_i),
        .ctrl_o      (ctrl),
        .reg1_read_o (reg1_read_o),
        .reg2_read_o (reg2_read_o),
        .reg1_addr_o (reg1_addr_o),
        .reg2_addr_o (reg2_addr_o),
        .imm_o       (imm)
    );

    // operand 1, rs side
    id_operand_sel u_op1 (
        .read_i     (reg1_read_o),
        .addr_i     (reg1_addr_o),
        .reg_data_i (reg1_data_i),
        .imm_i      (imm),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .operand_o  (op1)
    );

    // operand 2, rt side
    id_operand_sel u_op2 (
        .read_i     (reg2_read_o),
        .addr_i     (reg2_addr_o),
        .reg_data_i (reg2_data_i),
        .imm_i      (imm),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .operand_o  (op2)
    );

    id_ex_reg u_id_ex (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .ctrl_i  (ctrl),
        .reg1_i  (op1),
        .reg2_i  (op2),
        .id_ex_o (id_ex_o)
    );

endmodule

// File: id_ex_reg.sv
`timescale 1ns/10ps

module id_ex_reg (
    input  logic                clk_i,
    input  logic                reset_i,
    input  id_pkg::id_ctrl_t    ctrl_i,
    input  mips_isa_pkg::word_t reg1_i,
    input  mips_isa_pkg::word_t reg2_i,
    output id_pkg::id_ex_t      id_ex_o
);

    // one instruction per cycle, no stall
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            id_ex_o.ctrl.aluop        <= id_pkg::ALU_NOP;
            id_ex_o.ctrl.alusel       <= id_pkg::SEL_NOP;
            id_ex_o.ctrl.wd           <= mips_isa_pkg::NOP_REG_ADDR;
            id_ex_o.ctrl.wreg         <= 1'b0;
            id_ex_o.ctrl.inst_invalid <= 1'b0;
            id_ex_o.reg1              <= mips_isa_pkg::ZERO_WORD;
            id_ex_o.reg2              <= mips_isa_pkg::ZERO_WORD;
        end else begin
            id_ex_o.ctrl <= ctrl_i;
            id_ex_o.reg1 <= reg1_i;
            id_ex_o.reg2 <= reg2_i;
        end
    end

endmodule

// File: id_operand_sel.sv
`timescale 1ns/10ps

module id_operand_sel (
    input  logic                    read_i,
    input  mips_isa_pkg::reg_addr_t addr_i,
    input  mips_isa_pkg::word_t     reg_data_i,
    input  mips_isa_pkg::word_t     imm_i,
    input  id_pkg::fwd_src_t        ex_fwd_i,
    input  id_pkg::fwd_src_t        mem_fwd_i,
    output mips_isa_pkg::word_t     operand_o
);

    logic ex_hit;
    logic mem_hit;

    // a later stage is about to write the register being read
    assign ex_hit  = ex_fwd_i.wreg && (ex_fwd_i.wd == addr_i);
    assign mem_hit = mem_fwd_i.wreg && (mem_fwd_i.wd == addr_i);

    // execute is younger than memory, so it wins when both match
    always_comb begin
        if (!read_i) begin
            operand_o = imm_i;
        end else if (ex_hit) begin
            operand_o = ex_fwd_i.wdata;
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.wdata;
        end else begin
            operand_o = reg_data_i;
        end
    end

endmodule

// File: id_decoder.sv
`timescale 1ns/10ps

module id_decoder (
    input  mips_isa_pkg::word_t     inst_i,
    output id_pkg::id_ctrl_t        ctrl_o,
    output logic                    reg1_read_o,
    output logic                    reg2_read_o,
    output mips_isa_pkg::reg_addr_t reg1_addr_o,
    output mips_isa_pkg::reg_addr_t reg2_addr_o,
    output mips_isa_pkg::word_t     imm_o
);

    mips_isa_pkg::opcode_t   opcode;
    mips_isa_pkg::reg_addr_t rs;
    mips_isa_pkg::reg_addr_t rt;
    mips_isa_pkg::reg_addr_t rd;
    mips_isa_pkg::shamt_t    shamt;
    mips_isa_pkg::funct_t    funct;
    mips_isa_pkg::imm16_t    imm16;

    // instruction fields
    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign funct  = inst_i[5:0];
    assign imm16  = inst_i[15:0];

    // register file is always addressed by rs and rt
    assign reg1_addr_o = rs;
    assign reg2_addr_o = rt;

    // bundle of a recognized instruction that writes a register
    function automatic id_pkg::id_ctrl_t valid_ctrl(
        input id_pkg::alu_op_e          op,
        input id_pkg::alu_sel_e         sel,
        input mips_isa_pkg::reg_addr_t  dst
    );
        id_pkg::id_ctrl_t c;
        c.aluop        = op;
        c.alusel       = sel;
        c.wd           = dst;
        c.wreg         = 1'b1;
        c.inst_invalid = 1'b0;
        return c;
    endfunction

    always_comb begin
        logic rform;
        // invalid NOP unless something below matches
        ctrl_o.aluop        = id_pkg::ALU_NOP;
        ctrl_o.alusel       = id_pkg::SEL_NOP;
        ctrl_o.wd           = mips_isa_pkg::NOP_REG_ADDR;
        ctrl_o.wreg         = 1'b0;
        ctrl_o.inst_invalid = 1'b1;
        reg1_read_o         = 1'b0;
        reg2_read_o         = 1'b0;
        imm_o               = mips_isa_pkg::ZERO_WORD;
        rform               = 1'b1;

        case (opcode)
            mips_isa_pkg::OP_SPECIAL: begin
                if (rs == '0 && (funct == mips_isa_pkg::FN_SLL ||
                                 funct == mips_isa_pkg::FN_SRL ||
                                 funct == mips_isa_pkg::FN_SRA)) begin
                    // shift by immediate reads only rt
                    case (funct)
                        mips_isa_pkg::FN_SRL:
                            ctrl_o = valid_ctrl(id_pkg::ALU_SRL, id_pkg::SEL_SHIFT, rd);
                        mips_isa_pkg::FN_SRA:
                            ctrl_o = valid_ctrl(id_pkg::ALU_SRA, id_pkg::SEL_SHIFT, rd);
                        default:
                            ctrl_o = valid_ctrl(id_pkg::ALU_SLL, id_pkg::SEL_SHIFT, rd);
                    endcase
                    reg2_read_o = 1'b1;
                    imm_o       = {27'b0, shamt};
                end else if (shamt == '0) begin
                    case (funct)
                        mips_isa_pkg::FN_OR:
                            ctrl_o = valid_ctrl(id_pkg::ALU_OR, id_pkg::SEL_LOGIC, rd);
                        mips_isa_pkg::FN_AND:
                            ctrl_o = valid_ctrl(id_pkg::ALU_AND, id_pkg::SEL_LOGIC, rd);
                        mips_isa_pkg::FN_XOR:
                            ctrl_o = valid_ctrl(id_pkg::ALU_XOR, id_pkg::SEL_LOGIC, rd);
                        mips_isa_pkg::FN_NOR:
                            ctrl_o = valid_ctrl(id_pkg::ALU_NOR, id_pkg::SEL_LOGIC, rd);
                        mips_isa_pkg::FN_SLLV:
                            ctrl_o = valid_ctrl(id_pkg::ALU_SLL, id_pkg::SEL_SHIFT, rd);
                        mips_isa_pkg::FN_SRLV:
                            ctrl_o = valid_ctrl(id_pkg::ALU_SRL, id_pkg::SEL_SHIFT, rd);
                        mips_isa_pkg::FN_SRAV:
                            ctrl_o = valid_ctrl(id_pkg::ALU_SRA, id_pkg::SEL_SHIFT, rd);
                        mips_isa_pkg::FN_ADD:
                            ctrl_o = valid_ctrl(id_pkg::ALU_ADD, id_pkg::SEL_ARITH, rd);
                        mips_isa_pkg::FN_ADDU:
                            ctrl_o = valid_ctrl(id_pkg::ALU_ADDU, id_pkg::SEL_ARITH, rd);
                        mips_isa_pkg::FN_SUB:
                            ctrl_o = valid_ctrl(id_pkg::ALU_SUB, id_pkg::SEL_ARITH, rd);
                        mips_isa_pkg::FN_SUBU:
                            ctrl_o = valid_ctrl(id_pkg::ALU_SUBU, id_pkg::SEL_ARITH, rd);
                        mips_isa_pkg::FN_SLT:
                            ctrl_o = valid_ctrl(id_pkg::ALU_SLT, id_pkg::SEL_ARITH, rd);
                        mips_isa_pkg::FN_SLTU:
                            ctrl_o = valid_ctrl(id_pkg::ALU_SLTU, id_pkg::SEL_ARITH, rd);
                        default:
                            rform = 1'b0;
                    endcase
                    // register forms read both sources
                    reg1_read_o = rform;
                    reg2_read_o = rform;
                end
            end
            // immediate forms read rs and write rt with the immediate on operand 2
            mips_isa_pkg::OP_ORI: begin
                ctrl_o      = valid_ctrl(id_pkg::ALU_OR, id_pkg::SEL_LOGIC, rt);
                reg1_read_o = 1'b1;
                imm_o       = {16'b0, imm16};
            end
            mips_isa_pkg::OP_ANDI: begin
                ctrl_o      = valid_ctrl(id_pkg::ALU_AND, id_pkg::SEL_LOGIC, rt);
                reg1_read_o = 1'b1;
                imm_o       = {16'b0, imm16};
            end
            mips_isa_pkg::OP_XORI: begin
                ctrl_o      = valid_ctrl(id_pkg::ALU_XOR, id_pkg::SEL_LOGIC, rt);
                reg1_read_o = 1'b1;
                imm_o       = {16'b0, imm16};
            end
            mips_isa_pkg::OP_LUI: begin
                // or with rs and the field moved to the upper half
                ctrl_o      = valid_ctrl(id_pkg::ALU_OR, id_pkg::SEL_LOGIC, rt);
                reg1_read_o = 1'b1;
                imm_o       = {imm16, 16'b0};
            end
            mips_isa_pkg::OP_ADDI: begin
                ctrl_o      = valid_ctrl(id_pkg::ALU_ADDI, id_pkg::SEL_ARITH, rt);
                reg1_read_o = 1'b1;
                imm_o       = {{16{imm16[15]}}, imm16};
            end
            mips_isa_pkg::OP_ADDIU: begin
                ctrl_o      = valid_ctrl(id_pkg::ALU_ADDIU, id_pkg::SEL_ARITH, rt);
                reg1_read_o = 1'b1;
                imm_o       = {{16{imm16[15]}}, imm16};
            end
            mips_isa_pkg::OP_SLTI: begin
                ctrl_o      = valid_ctrl(id_pkg::ALU_SLT, id_pkg::SEL_ARITH, rt);
                reg1_read_o = 1'b1;
                imm_o       = {{16{imm16[15]}}, imm16};
            end
            mips_isa_pkg::OP_SLTIU: begin
                // compare is unsigned but the field is still sign-extended
                ctrl_o      = valid_ctrl(id_pkg::ALU_SLTU, id_pkg::SEL_ARITH, rt);
                reg1_read_o = 1'b1;
                imm_o       = {{16{imm16[15]}}, imm16};
            end
            default: begin
                // unknown opcode keeps the invalid NOP bundle
            end
        endcase
    end

endmodule

// File: id_pkg.sv
package id_pkg;

    // operation code handed to the execute stage
    typedef enum logic [7:0] {
        ALU_NOP   = 8'b0000_0000,
        ALU_SRL   = 8'b0000_0010,
        ALU_SRA   = 8'b0000_0011,
        ALU_ADD   = 8'b0010_0000,
        ALU_ADDU  = 8'b0010_0001,
        ALU_SUB   = 8'b0010_0010,
        ALU_SUBU  = 8'b0010_0011,
        ALU_AND   = 8'b0010_0100,
        ALU_OR    = 8'b0010_0101,
        ALU_XOR   = 8'b0010_0110,
        ALU_NOR   = 8'b0010_0111,
        ALU_SLT   = 8'b0010_1010,
        ALU_SLTU  = 8'b0010_1011,
        ALU_ADDI  = 8'b0101_0101,
        ALU_ADDIU = 8'b0101_0110,
        ALU_SLL   = 8'b0111_1100
    } alu_op_e;

    // which execute result is written back
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_ARITH = 3'b100
    } alu_sel_e;

    typedef struct packed {
        alu_op_e                aluop;
        alu_sel_e               alusel;
        mips_isa_pkg::reg_addr_t wd;
        logic                   wreg;
        logic                   inst_invalid;
    } id_ctrl_t;

    // pending register write of a later stage
    typedef struct packed {
        logic                    wreg;
        mips_isa_pkg::reg_addr_t wd;
        mips_isa_pkg::word_t     wdata;
    } fwd_src_t;

    typedef struct packed {
        id_ctrl_t            ctrl;
        mips_isa_pkg::word_t reg1;
        mips_isa_pkg::word_t reg2;
    } id_ex_t;

endpackage

// File: mips_isa_pkg.sv
package mips_isa_pkg;

    // field widths of the instruction word
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int SHAMT_W    = 5;
    localparam int IMM_W      = 16;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [OPCODE_W-1:0]   opcode_t;
    typedef logic [FUNCT_W-1:0]    funct_t;
    typedef logic [SHAMT_W-1:0]    shamt_t;
    typedef logic [IMM_W-1:0]      imm16_t;

    // primary opcodes
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_ADDI    = 6'b001000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;

    // SPECIAL function codes
    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;
    localparam funct_t FN_SLLV = 6'b000100;
    localparam funct_t FN_SRLV = 6'b000110;
    localparam funct_t FN_SRAV = 6'b000111;
    localparam funct_t FN_ADD  = 6'b100000;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUB  = 6'b100010;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;
    localparam funct_t FN_SLT  = 6'b101010;
    localparam funct_t FN_SLTU = 6'b101011;

    localparam word_t     ZERO_WORD    = 32'h0000_0000;
    localparam reg_addr_t NOP_REG_ADDR = 5'b00000;

endpackage
